// File: Bender.yml
package:
  name: cpu

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpuPkg.sv
      - hw/controlUnit.sv
      - hw/alu.sv
      - hw/regFile.sv
      - hw/dataMem.sv
      - hw/hostCtrl.sv
      - hw/cpuCore.sv
      - hw/cpuTop.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/cpuTb.sv

// File: cpu.f
+incdir+hw
hw/cpuPkg.sv
hw/controlUnit.sv
hw/alu.sv
hw/regFile.sv
hw/dataMem.sv
hw/hostCtrl.sv
hw/cpuCore.sv
hw/cpuTop.sv
sim/cpuTb.sv

// File: hw/alu.sv
// combinational ALU of the core; R-type ops are resolved from the function field
`default_nettype none

module alu (
	input  cpuPkg::aluOp_t aluOp,
	input  cpuPkg::funct_t funct,
	input  cpuPkg::word_t  a,
	input  cpuPkg::word_t  b,
	output cpuPkg::word_t  result,
	output logic           zero
);

	always_comb
	begin
		result = '0;
		case (aluOp)
			cpuPkg::ALU_OR:
				result = a | b;
			cpuPkg::ALU_ADD:
				result = a + b;
			cpuPkg::ALU_AND:
				result = a & b;
			cpuPkg::ALU_SUB:
				result = a - b;
			// upper half from the immediate
			cpuPkg::ALU_LUI:
				result = b << 16;
			cpuPkg::ALU_FUNCT:
			begin
				case (funct)
					cpuPkg::FN_ADD:
						result = a + b;
					cpuPkg::FN_SUB:
						result = a - b;
					cpuPkg::FN_AND:
						result = a & b;
					cpuPkg::FN_OR:
						result = a | b;
					cpuPkg::FN_SLT:
						result = cpuPkg::word_t'($signed(a) < $signed(b));
					default:
						result = '0;
				endcase
			end
			default:
				result = '0;
		endcase
	end

	// branch compare
	assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hw/controlUnit.sv
// opcode decoder of the core; turns the opcode into the control word, all zero under stall
`default_nettype none

module controlUnit (
	input  cpuPkg::opcode_t  opcode,
	input  logic             stall,
	output cpuPkg::ctrlSig_t ctrl
);

	always_comb
	begin
		ctrl = '0;
		if (!stall)
		begin
			case (opcode)
				cpuPkg::OP_LW:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.memToReg = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.aluSrc = 1'b1;
					ctrl.isSigned = 1'b1;
					ctrl.aluOp = cpuPkg::ALU_ADD;
				end
				cpuPkg::OP_LUI:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrc = 1'b1;
					ctrl.isSigned = 1'b1;
					ctrl.aluOp = cpuPkg::ALU_LUI;
				end
				cpuPkg::OP_LBU:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.memToReg = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.aluSrc = 1'b1;
					ctrl.isSigned = 1'b1;
					ctrl.byteAccess = 1'b1;
					ctrl.aluOp = cpuPkg::ALU_ADD;
				end
				cpuPkg::OP_SB, cpuPkg::OP_SW:
				begin
					ctrl.memWrite = 1'b1;
					ctrl.aluSrc = 1'b1;
					ctrl.isSigned = 1'b1;
					ctrl.byteAccess = (opcode == cpuPkg::OP_SB);
					ctrl.aluOp = cpuPkg::ALU_ADD;
				end
				cpuPkg::OP_RTYPE:
				begin
					ctrl.regDst = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.aluOp = cpuPkg::ALU_FUNCT;
				end
				// immediate ops zero-extend
				cpuPkg::OP_ADDI, cpuPkg::OP_ANDI, cpuPkg::OP_ORI:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrc = 1'b1;
					if (opcode == cpuPkg::OP_ADDI)
						ctrl.aluOp = cpuPkg::ALU_ADD;
					else if (opcode == cpuPkg::OP_ANDI)
						ctrl.aluOp = cpuPkg::ALU_AND;
					else
						ctrl.aluOp = cpuPkg::ALU_OR;
				end
				cpuPkg::OP_BEQ, cpuPkg::OP_BNE:
				begin
					ctrl.branchEqual = (opcode == cpuPkg::OP_BEQ);
					ctrl.branchNotEqual = (opcode == cpuPkg::OP_BNE);
					ctrl.isSigned = 1'b1;
					ctrl.aluOp = cpuPkg::ALU_SUB;
				end
				// link write comes from jumpAndLink, not regWrite
				cpuPkg::OP_JAL:
				begin
					ctrl.jumpAndLink = 1'b1;
					ctrl.aluOp = cpuPkg::ALU_ADD;
				end
				cpuPkg::OP_J:
					ctrl.jump = 1'b1;
				default:
					ctrl = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/cpuCore.sv
// single-cycle datapath of the processor; PC, operand selection, branches, jumps and writeback
`default_nettype none
`include "cpu_params.svh"

module cpuCore (
	input  logic              clk,
	input  logic              rst,
	input  cpuPkg::word_t     instr,
	input  logic              stall,
	input  cpuPkg::regAddr_t  dbgAddr,
	output cpuPkg::imemAddr_t fetchAddr,
	output cpuPkg::word_t     dbgData
);

	cpuPkg::ctrlSig_t ctrl;
	cpuPkg::word_t pc;
	cpuPkg::word_t pcPlus4;
	cpuPkg::word_t branchTarget;
	cpuPkg::word_t jumpTarget;
	cpuPkg::word_t nextPc;
	cpuPkg::word_t immSext;
	cpuPkg::word_t immExt;
	cpuPkg::word_t rsData;
	cpuPkg::word_t rtData;
	cpuPkg::word_t opB;
	cpuPkg::word_t aluResult;
	cpuPkg::word_t memData;
	cpuPkg::word_t wData;
	cpuPkg::regAddr_t wAddr;
	logic aluZero;
	logic takeBranch;
	logic regWe;

	controlUnit decode (
		.opcode(cpuPkg::opcode_t'(instr[31:26])),
		.stall (stall),
		.ctrl  (ctrl)
	);

	// immediate extension
	assign immSext = {{16{instr[15]}}, instr[15:0]};
	assign immExt = ctrl.isSigned ? immSext : {16'd0, instr[15:0]};
	assign opB = ctrl.aluSrc ? immExt : rtData;

	alu exec (
		.aluOp (ctrl.aluOp),
		.funct (cpuPkg::funct_t'(instr[5:0])),
		.a     (rsData),
		.b     (opB),
		.result(aluResult),
		.zero  (aluZero)
	);

	dataMem dmem (
		.clk       (clk),
		.rst       (rst),
		.addr      (aluResult),
		.wData     (rtData),
		.read      (ctrl.memRead),
		.write     (ctrl.memWrite),
		.byteAccess(ctrl.byteAccess),
		.rData     (memData)
	);

	// jal links pc+4 into the link register
	assign regWe = ctrl.regWrite | ctrl.jumpAndLink;
	assign wAddr = ctrl.jumpAndLink ? cpuPkg::regAddr_t'(`CPU_LINK_REG)
		: (ctrl.regDst ? instr[15:11] : instr[20:16]);
	assign wData = ctrl.jumpAndLink ? pcPlus4 : (ctrl.memToReg ? memData : aluResult);

	regFile regs (
		.clk    (clk),
		.rst    (rst),
		.rsAddr (instr[25:21]),
		.rtAddr (instr[20:16]),
		.we     (regWe),
		.wAddr  (wAddr),
		.wData  (wData),
		.dbgAddr(dbgAddr),
		.rsData (rsData),
		.rtData (rtData),
		.dbgData(dbgData)
	);

	// next pc
	assign pcPlus4 = pc + 32'd4;
	assign branchTarget = pcPlus4 + (immSext << 2);
	assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
	assign takeBranch = (ctrl.branchEqual && aluZero) || (ctrl.branchNotEqual && !aluZero);

	always_comb
	begin
		if (ctrl.jump || ctrl.jumpAndLink)
			nextPc = jumpTarget;
		else if (takeBranch)
			nextPc = branchTarget;
		else
			nextPc = pcPlus4;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (!stall)
			pc <= nextPc;
	end

	assign fetchAddr = pc[$bits(cpuPkg::imemAddr_t)+1:2];

endmodule

`default_nettype wire

// File: hw/cpuPkg.sv
// common types for the processor core, host control and testbench, referenced by scoped name
`default_nettype none
`include "cpu_params.svh"

package cpuPkg;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [$clog2(`CPU_IMEM_WORDS)-1:0] imemAddr_t;
	typedef logic [15:0] stepCount_t;

	typedef enum logic [5:0] {
		OP_J     = 6'h02,
		OP_RTYPE = 6'h03,
		OP_BNE   = 6'h04,
		OP_BEQ   = 6'h05,
		OP_JAL   = 6'h07,
		OP_ADDI  = 6'h09,
		OP_ANDI  = 6'h0C,
		OP_ORI   = 6'h0E,
		OP_LUI   = 6'h0F,
		OP_LW    = 6'h12,
		OP_LBU   = 6'h22,
		OP_SB    = 6'h28,
		OP_SW    = 6'h2B
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_NONE  = 4'h0,
		ALU_FUNCT = 4'h2,
		ALU_OR    = 4'h3,
		ALU_ADD   = 4'h4,
		ALU_AND   = 4'h5,
		ALU_SUB   = 4'h7,
		ALU_LUI   = 4'hB
	} aluOp_t;

	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2A
	} funct_t;

	typedef struct packed {
		logic regDst;
		logic regWrite;
		logic memToReg;
		logic jump;
		logic jumpAndLink;
		logic memRead;
		logic memWrite;
		logic branchEqual;
		logic branchNotEqual;
		logic aluSrc;
		logic isSigned;
		logic byteAccess;
		aluOp_t aluOp;
	} ctrlSig_t;

	// host program load into instruction memory
	typedef struct packed {
		logic en;
		imemAddr_t addr;
		word_t data;
	} loadReq_t;

endpackage

`default_nettype wire

// File: hw/cpuTop.sv
// processor top level; joins the host control block and the core to the outside ports
`default_nettype none

module cpuTop (
	input  logic               clk,
	input  logic               rst,
	input  cpuPkg::loadReq_t   load,
	input  logic               start,
	input  cpuPkg::stepCount_t stepLimit,
	input  cpuPkg::regAddr_t   dbgAddr,
	output cpuPkg::word_t      dbgData,
	output logic               running,
	output cpuPkg::stepCount_t retired,
	output logic               done
);

	cpuPkg::word_t instr;
	cpuPkg::imemAddr_t fetchAddr;
	logic stall;

	hostCtrl host (
		.clk      (clk),
		.rst      (rst),
		.load     (load),
		.start    (start),
		.stepLimit(stepLimit),
		.fetchAddr(fetchAddr),
		.instr    (instr),
		.stall    (stall),
		.running  (running),
		.done     (done),
		.retired  (retired)
	);

	cpuCore core (
		.clk      (clk),
		.rst      (rst),
		.instr    (instr),
		.stall    (stall),
		.dbgAddr  (dbgAddr),
		.fetchAddr(fetchAddr),
		.dbgData  (dbgData)
	);

endmodule

`default_nettype wire

// File: hw/cpu_params.svh
// size macros shared by the processor RTL and testbench; include wherever a size is needed
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and instruction width
`define CPU_WORD_W 32

// instruction memory depth in words
`define CPU_IMEM_WORDS 256

// data memory size in bytes
`define CPU_DMEM_BYTES 1024

// jump-and-link return register
`define CPU_LINK_REG 31

`endif

// File: hw/dataMem.sv
// byte-addressed little-endian data memory of the core with word and byte accesses
`default_nettype none
`include "cpu_params.svh"

module dataMem (
	input  logic          clk,
	input  logic          rst,
	input  cpuPkg::word_t addr,
	input  cpuPkg::word_t wData,
	input  logic          read,
	input  logic          write,
	input  logic          byteAccess,
	output cpuPkg::word_t rData
);

	localparam int addrBits = $clog2(`CPU_DMEM_BYTES);

	logic [7:0] mem [`CPU_DMEM_BYTES];
	logic [addrBits-1:0] byteAddr;
	logic [addrBits-3:0] wordIdx;

	// address wraps at the memory size
	assign byteAddr = addr[addrBits-1:0];
	assign wordIdx = byteAddr[addrBits-1:2];

	always_ff @(posedge clk)
	begin
		if (rst)
			mem <= '{default: '0};
		else if (write)
		begin
			if (byteAccess)
				mem[byteAddr] <= wData[7:0];
			else
			begin
				mem[{wordIdx, 2'd0}] <= wData[7:0];
				mem[{wordIdx, 2'd1}] <= wData[15:8];
				mem[{wordIdx, 2'd2}] <= wData[23:16];
				mem[{wordIdx, 2'd3}] <= wData[31:24];
			end
		end
	end

	always_comb
	begin
		rData = '0;
		if (read)
		begin
			if (byteAccess)
				rData = {24'd0, mem[byteAddr]};
			else
				rData = {mem[{wordIdx, 2'd3}], mem[{wordIdx, 2'd2}],
					mem[{wordIdx, 2'd1}], mem[{wordIdx, 2'd0}]};
		end
	end

endmodule

`default_nettype wire

// File: hw/hostCtrl.sv
// host side of the processor; program memory, run flag and step limit, stalls the core when idle
`default_nettype none
`include "cpu_params.svh"

module hostCtrl (
	input  logic               clk,
	input  logic               rst,
	input  cpuPkg::loadReq_t   load,
	input  logic               start,
	input  cpuPkg::stepCount_t stepLimit,
	input  cpuPkg::imemAddr_t  fetchAddr,
	output cpuPkg::word_t      instr,
	output logic               stall,
	output logic               running,
	output logic               done,
	output cpuPkg::stepCount_t retired
);

	cpuPkg::word_t imem [`CPU_IMEM_WORDS];
	cpuPkg::stepCount_t nextRetired;

	// program can only change while stopped
	always_ff @(posedge clk)
	begin
		if (load.en && !running)
			imem[load.addr] <= load.data;
	end

	assign instr = imem[fetchAddr];
	assign stall = !running;
	assign nextRetired = retired + 1'b1;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			running <= 1'b0;
			done <= 1'b0;
			retired <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (running)
			begin
				// one instruction commits per running cycle
				retired <= nextRetired;
				if (nextRetired == stepLimit)
				begin
					running <= 1'b0;
					done <= 1'b1;
				end
			end
			else if (start)
			begin
				retired <= '0;
				if (stepLimit == '0)
					done <= 1'b1;
				else
					running <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/regFile.sv
// 32-entry register file with two operand reads, one debug read and one write; r0 reads zero
`default_nettype none

module regFile (
	input  logic             clk,
	input  logic             rst,
	input  cpuPkg::regAddr_t rsAddr,
	input  cpuPkg::regAddr_t rtAddr,
	input  logic             we,
	input  cpuPkg::regAddr_t wAddr,
	input  cpuPkg::word_t    wData,
	input  cpuPkg::regAddr_t dbgAddr,
	output cpuPkg::word_t    rsData,
	output cpuPkg::word_t    rtData,
	output cpuPkg::word_t    dbgData
);

	cpuPkg::word_t regs [32];

	// r0 never written, so it stays at its reset value
	always_ff @(posedge clk)
	begin
		if (rst)
			regs <= '{default: '0};
		else if (we && (wAddr != '0))
			regs[wAddr] <= wData;
	end

	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];
	assign dbgData = regs[dbgAddr];

endmodule

`default_nettype wire

// File: sim/cpuTb.sv
// self-checking testbench for cpuTop; runs directed and random programs against a reference model
`default_nettype none
`include "cpu_params.svh"

module cpuTb;

	localparam int aluSteps = 15;
	localparam int memSteps = 21;
	localparam int ctrlSteps = 12;
	localparam int runSteps = 10;
	localparam int randSteps = 40;
	localparam int randCount = 10;
	localparam int totalSteps = aluSteps + memSteps + ctrlSteps + runSteps + randCount * randSteps;
	// reset, program load, run tail and register readback per run
	localparam int runCount = 7 + randCount;
	localparam int runOverhead = 120;
	localparam int watchdogTime = (totalSteps + runCount * runOverhead) * 20 + 2000;

	logic clk;
	logic rst;
	cpuPkg::loadReq_t load;
	logic start;
	cpuPkg::stepCount_t stepLimit;
	cpuPkg::regAddr_t dbgAddr;
	cpuPkg::word_t dbgData;
	logic running;
	cpuPkg::stepCount_t retired;
	logic done;

	int errors;
	int passed;
	int failed;

	// reference model state
	cpuPkg::word_t prog [`CPU_IMEM_WORDS];
	cpuPkg::word_t mRegs [32];
	logic [7:0] mMem [`CPU_DMEM_BYTES];
	cpuPkg::word_t mPc;

	cpuTop dut_i (
		.clk      (clk),
		.rst      (rst),
		.load     (load),
		.start    (start),
		.stepLimit(stepLimit),
		.dbgAddr  (dbgAddr),
		.dbgData  (dbgData),
		.running  (running),
		.retired  (retired),
		.done     (done)
	);

	always #10 clk = !clk;

	initial
	begin
		#(watchdogTime);
		$display("watchdog expired before all tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic cpuPkg::word_t encI(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic cpuPkg::word_t encR(input int rs, input int rt, input int rd,
		input logic [5:0] fn);
		return {6'(cpuPkg::OP_RTYPE), 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic cpuPkg::word_t encJ(input logic [5:0] op, input int idx);
		return {op, 26'(idx)};
	endfunction

	function automatic void setReg(input int idx, input cpuPkg::word_t val);
		if (idx != 0)
			mRegs[idx] = val;
	endfunction

	// executes one instruction of prog by the instruction-set rules
	task automatic modelStep();
		cpuPkg::word_t ins;
		cpuPkg::word_t a;
		cpuPkg::word_t b;
		cpuPkg::word_t simm;
		cpuPkg::word_t zimm;
		cpuPkg::word_t res;
		cpuPkg::word_t pcNext;
		int base;
		int rs;
		int rt;
		int rd;
		ins = prog[(mPc >> 2) % `CPU_IMEM_WORDS];
		rs = ins[25:21];
		rt = ins[20:16];
		rd = ins[15:11];
		a = mRegs[rs];
		b = mRegs[rt];
		simm = {{16{ins[15]}}, ins[15:0]};
		zimm = {16'd0, ins[15:0]};
		pcNext = mPc + 4;
		base = int'((a + simm) % `CPU_DMEM_BYTES);
		case (ins[31:26])
			cpuPkg::OP_RTYPE:
			begin
				case (ins[5:0])
					cpuPkg::FN_ADD:
						res = a + b;
					cpuPkg::FN_SUB:
						res = a - b;
					cpuPkg::FN_AND:
						res = a & b;
					cpuPkg::FN_OR:
						res = a | b;
					cpuPkg::FN_SLT:
						res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:
						res = 32'd0;
				endcase
				setReg(rd, res);
			end
			cpuPkg::OP_ADDI:
				setReg(rt, a + zimm);
			cpuPkg::OP_ANDI:
				setReg(rt, a & zimm);
			cpuPkg::OP_ORI:
				setReg(rt, a | zimm);
			cpuPkg::OP_LUI:
				setReg(rt, {ins[15:0], 16'd0});
			cpuPkg::OP_LW:
			begin
				base = (base / 4) * 4;
				setReg(rt, {mMem[base + 3], mMem[base + 2], mMem[base + 1], mMem[base]});
			end
			cpuPkg::OP_LBU:
				setReg(rt, {24'd0, mMem[base]});
			cpuPkg::OP_SW:
			begin
				base = (base / 4) * 4;
				mMem[base] = b[7:0];
				mMem[base + 1] = b[15:8];
				mMem[base + 2] = b[23:16];
				mMem[base + 3] = b[31:24];
			end
			cpuPkg::OP_SB:
				mMem[base] = b[7:0];
			cpuPkg::OP_BEQ:
				if (a == b)
					pcNext = mPc + 4 + (simm << 2);
			cpuPkg::OP_BNE:
				if (a != b)
					pcNext = mPc + 4 + (simm << 2);
			cpuPkg::OP_J:
				pcNext = {pcNext[31:28], ins[25:0], 2'b00};
			cpuPkg::OP_JAL:
			begin
				setReg(`CPU_LINK_REG, pcNext);
				pcNext = {pcNext[31:28], ins[25:0], 2'b00};
			end
			default:
				res = 32'd0;
		endcase
		mPc = pcNext;
	endtask

	task automatic checkWord(input string name, input cpuPkg::word_t expected,
		input cpuPkg::word_t actual);
		assert (actual === expected)
		else
		begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// every task below starts and ends 2 units after a rising edge
	task automatic resetDut();
		rst = 1'b1;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		mPc = '0;
		for (int i = 0; i < 32; i++)
			mRegs[i] = '0;
		for (int i = 0; i < `CPU_DMEM_BYTES; i++)
			mMem[i] = '0;
	endtask

	task automatic loadProgram(input int words);
		for (int i = 0; i < words; i++)
		begin
			load.en = 1'b1;
			load.addr = cpuPkg::imemAddr_t'(i);
			load.data = prog[i];
			@(posedge clk);
			#2;
		end
		load.en = 1'b0;
	endtask

	task automatic checkRegs();
		for (int i = 0; i < 32; i++)
		begin
			dbgAddr = cpuPkg::regAddr_t'(i);
			@(negedge clk);
			checkWord($sformatf("r%0d", i), mRegs[i], dbgData);
			@(posedge clk);
			#2;
		end
	endtask

	// start a run, watch running and done, then compare with the model
	task automatic runAndCheck(input int steps, input bit loadDuring);
		int cycles;
		int runCycles;
		int donePulses;
		stepLimit = cpuPkg::stepCount_t'(steps);
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		if (loadDuring)
		begin
			load.en = 1'b1;
			load.addr = cpuPkg::imemAddr_t'(6);
			load.data = encI(cpuPkg::OP_ADDI, 0, 20, 16'h0BAD);
		end
		cycles = 0;
		runCycles = 0;
		donePulses = 0;
		while (donePulses == 0 && cycles < steps + 8)
		begin
			@(negedge clk);
			if (running)
				runCycles++;
			if (done)
				donePulses++;
			cycles++;
			@(posedge clk);
			#2;
			load.en = 1'b0;
		end
		// done must not repeat
		@(negedge clk);
		if (done)
			donePulses++;
		if (running)
			runCycles++;
		@(posedge clk);
		#2;
		assert (donePulses != 0)
		else
		begin
			$display("run of %0d steps never raised done", steps);
			errors++;
		end
		assert (donePulses < 2)
		else
		begin
			$display("done pulsed more than once in a run of %0d steps", steps);
			errors++;
		end
		assert (runCycles == steps)
		else
		begin
			$display("core ran for %0d cycles instead of %0d", runCycles, steps);
			errors++;
		end
		assert (!running)
		else
		begin
			$display("running stayed high after the run ended");
			errors++;
		end
		checkWord("retired", cpuPkg::word_t'(steps), cpuPkg::word_t'(retired));
		repeat (steps) modelStep();
		checkRegs();
	endtask

	task automatic finishTest(input string name, input int errBefore);
		if (errors == errBefore)
		begin
			passed++;
			$display("test %s passed", name);
		end
		else
		begin
			failed++;
			$display("test %s failed with %0d errors", name, errors - errBefore);
		end
	endtask

	function automatic cpuPkg::word_t randomInstr();
		int rs;
		int rt;
		int rd;
		logic [15:0] imm;
		logic [5:0] fn;
		cpuPkg::word_t ins;
		rs = $urandom_range(0, 7);
		rt = $urandom_range(1, 7);
		rd = $urandom_range(0, 7);
		imm = 16'($urandom);
		case ($urandom_range(0, 4))
			0:
				fn = cpuPkg::FN_ADD;
			1:
				fn = cpuPkg::FN_SUB;
			2:
				fn = cpuPkg::FN_AND;
			3:
				fn = cpuPkg::FN_OR;
			default:
				fn = cpuPkg::FN_SLT;
		endcase
		case ($urandom_range(0, 8))
			0:
				ins = encI(cpuPkg::OP_ADDI, rs, rt, imm);
			1:
				ins = encI(cpuPkg::OP_ANDI, rs, rt, imm);
			2:
				ins = encI(cpuPkg::OP_ORI, rs, rt, imm);
			3:
				ins = encI(cpuPkg::OP_LUI, 0, rt, imm);
			4:
				ins = encR(rs, rt, rd, fn);
			5:
				ins = encI(cpuPkg::OP_SW, rs, rt, imm);
			6:
				ins = encI(cpuPkg::OP_SB, rs, rt, imm);
			7:
				ins = encI(cpuPkg::OP_LW, rs, rt, imm);
			default:
				ins = encI(cpuPkg::OP_LBU, rs, rt, imm);
		endcase
		return ins;
	endfunction

	initial
	begin
		int errBefore;
		clk = 1'b0;
		rst = 1'b1;
		load = '0;
		start = 1'b0;
		stepLimit = '0;
		dbgAddr = '0;
		errors = 0;
		passed = 0;
		failed = 0;
		void'($urandom(92006));
		for (int i = 0; i < `CPU_IMEM_WORDS; i++)
			prog[i] = '0;

		errBefore = errors;
		resetDut();
		checkWord("running", 32'd0, cpuPkg::word_t'(running));
		checkWord("done", 32'd0, cpuPkg::word_t'(done));
		checkWord("retired", 32'd0, cpuPkg::word_t'(retired));
		checkRegs();
		finishTest("reset", errBefore);

		// arithmetic, logic, r0 writes and zero-extended addi
		errBefore = errors;
		resetDut();
		prog[0] = encI(cpuPkg::OP_ADDI, 0, 1, 16'h1234);
		prog[1] = encI(cpuPkg::OP_ADDI, 0, 2, 16'h8001);
		prog[2] = encI(cpuPkg::OP_ORI, 1, 3, 16'hF0F0);
		prog[3] = encI(cpuPkg::OP_ANDI, 3, 4, 16'h00FF);
		prog[4] = encI(cpuPkg::OP_LUI, 0, 5, 16'hABCD);
		prog[5] = encR(1, 2, 6, cpuPkg::FN_ADD);
		prog[6] = encR(1, 2, 7, cpuPkg::FN_SUB);
		prog[7] = encR(3, 1, 8, cpuPkg::FN_AND);
		prog[8] = encR(5, 1, 9, cpuPkg::FN_OR);
		prog[9] = encR(7, 1, 10, cpuPkg::FN_SLT);
		prog[10] = encR(1, 7, 11, cpuPkg::FN_SLT);
		prog[11] = encI(cpuPkg::OP_ADDI, 0, 12, 16'h0005);
		prog[12] = encR(1, 2, 12, 6'h3F);
		prog[13] = encI(cpuPkg::OP_ADDI, 1, 0, 16'h0007);
		prog[14] = encR(1, 1, 0, cpuPkg::FN_ADD);
		loadProgram(aluSteps);
		runAndCheck(aluSteps, 1'b0);
		finishTest("alu", errBefore);

		// word and byte stores in every lane, loads back
		errBefore = errors;
		resetDut();
		prog[0] = encI(cpuPkg::OP_ADDI, 0, 1, 16'h0100);
		prog[1] = encI(cpuPkg::OP_LUI, 0, 2, 16'hDEAD);
		prog[2] = encI(cpuPkg::OP_ORI, 2, 2, 16'hBEEF);
		prog[3] = encI(cpuPkg::OP_SW, 1, 2, 16'h0000);
		for (int lane = 0; lane < 4; lane++)
		begin
			prog[4 + 2 * lane] = encI(cpuPkg::OP_ADDI, 0, 3, 16'(8'h11 * (lane + 1)));
			prog[5 + 2 * lane] = encI(cpuPkg::OP_SB, 1, 3, 16'(4 + lane));
		end
		prog[12] = encI(cpuPkg::OP_LW, 1, 4, 16'h0004);
		prog[13] = encI(cpuPkg::OP_LW, 1, 5, 16'h0000);
		prog[14] = encI(cpuPkg::OP_LBU, 1, 6, 16'h0001);
		prog[15] = encI(cpuPkg::OP_LBU, 1, 7, 16'h0003);
		prog[16] = encI(cpuPkg::OP_SB, 1, 2, 16'h0008);
		prog[17] = encI(cpuPkg::OP_LW, 1, 8, 16'h0008);
		prog[18] = encI(cpuPkg::OP_SW, 1, 4, 16'hFFFC);
		prog[19] = encI(cpuPkg::OP_LW, 0, 9, 16'h00FC);
		prog[20] = encI(cpuPkg::OP_LW, 1, 10, 16'h0002);
		loadProgram(memSteps);
		runAndCheck(memSteps, 1'b0);
		finishTest("memory", errBefore);

		// branches both ways, j and jal; the 0xBAD writes must be skipped
		errBefore = errors;
		resetDut();
		prog[0] = encI(cpuPkg::OP_ADDI, 0, 1, 16'h0005);
		prog[1] = encI(cpuPkg::OP_ADDI, 0, 2, 16'h0005);
		prog[2] = encI(cpuPkg::OP_BEQ, 1, 2, 16'h0001);
		prog[3] = encI(cpuPkg::OP_ADDI, 0, 10, 16'h0BAD);
		prog[4] = encI(cpuPkg::OP_BNE, 1, 2, 16'h0001);
		prog[5] = encI(cpuPkg::OP_ADDI, 0, 3, 16'h0001);
		prog[6] = encI(cpuPkg::OP_BEQ, 1, 3, 16'h0001);
		prog[7] = encI(cpuPkg::OP_ADDI, 0, 4, 16'h0002);
		prog[8] = encI(cpuPkg::OP_BNE, 1, 3, 16'h0001);
		prog[9] = encI(cpuPkg::OP_ADDI, 0, 11, 16'h0BAD);
		prog[10] = encJ(cpuPkg::OP_J, 12);
		prog[11] = encI(cpuPkg::OP_ADDI, 0, 12, 16'h0BAD);
		prog[12] = encJ(cpuPkg::OP_JAL, 15);
		prog[13] = encI(cpuPkg::OP_ADDI, 0, 5, 16'h0BAD);
		prog[14] = encI(cpuPkg::OP_ADDI, 0, 13, 16'h0BAD);
		prog[15] = encI(cpuPkg::OP_ADDI, 0, 6, 16'h0066);
		prog[16] = encR(`CPU_LINK_REG, 0, 7, cpuPkg::FN_ADD);
		loadProgram(17);
		runAndCheck(ctrlSteps, 1'b0);
		finishTest("control flow", errBefore);

		// step limit, dropped load, continued run and an empty run
		errBefore = errors;
		resetDut();
		for (int i = 0; i < runSteps; i++)
			prog[i] = encI(cpuPkg::OP_ADDI, i, i + 1, 16'(i + 1));
		loadProgram(runSteps);
		runAndCheck(4, 1'b1);
		runAndCheck(runSteps - 4, 1'b0);
		runAndCheck(0, 1'b0);
		finishTest("run control", errBefore);

		for (int t = 0; t < randCount; t++)
		begin
			errBefore = errors;
			resetDut();
			for (int i = 0; i < randSteps; i++)
				prog[i] = randomInstr();
			loadProgram(randSteps);
			runAndCheck(randSteps, 1'b0);
			finishTest($sformatf("random %0d", t), errBefore);
		end

		$display("tests passed: %0d, tests failed: %0d", passed, failed);
		if (failed == 0 && errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
